// ==== files.f ====
rtl/regbank_pkg.sv
rtl/bank_port_if.sv
rtl/registers_bank.sv
rtl/alu.sv
rtl/forward_unit.sv
rtl/exec_pipeline.sv
rtl/debug_unit.sv
rtl/regbank_top.sv
sim/regbank_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module regbank_tb -f files.f -o regbank_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/regbank_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// ==== sim/regbank_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module regbank_tb;

    import regbank_pkg::*;

    localparam int N_INSTR        = 300;
    localparam int N_RAND_DBG     = 12;
    localparam int N_DBG_OPS      = 2 * 33 + N_RAND_DBG + 4; // Full sweeps, random, tail
    localparam int TIMEOUT_CYCLES = 20 * N_INSTR + 20 * N_DBG_OPS;

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr_word;
    logic        instr_ready;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [31:0] wb_dat_in;
    logic [31:0] wb_dat_out;
    logic        wb_ack;

    logic [31:0] rand_state;
    logic [31:0] model_regs [32];
    logic [31:0] model_count;                // Accepted instructions
    logic [31:0] instr_list [N_INSTR];
    int          gap_list   [N_INSTR];       // Idle cycles before each word
    int          dbg_gap    [N_RAND_DBG];
    logic [5:0]  dbg_adr    [N_RAND_DBG];
    int          error_count;
    int          check_count;
    int          cycle_count;

    regbank_top #(
        .NB_DATA    (NB_DATA),
        .NB_ADDR    (NB_ADDR),
        .BANK_DEPTH (BANK_DEPTH)
    ) i_regbank_top (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_instr_valid (instr_valid),
        .i_instr       (instr_word),
        .o_instr_ready (instr_ready),
        .i_wb_cyc      (wb_cyc),
        .i_wb_stb      (wb_stb),
        .i_wb_we       (wb_we),
        .i_wb_adr      (wb_adr),
        .i_wb_dat      (wb_dat_in),
        .o_wb_dat      (wb_dat_out),
        .o_wb_ack      (wb_ack)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return {16'd0, rand_state[31:16]}; // Upper bits have the long period
    endfunction

    function automatic logic [5:0] pick_funct();
        case (next_rand() % 6)
            0:       return FN_ADD;
            1:       return FN_SUB;
            2:       return FN_AND;
            3:       return FN_OR;
            4:       return FN_XOR;
            default: return FN_SLT;
        endcase
    endfunction

    function automatic logic [31:0] make_instr(input int idx);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  opcode;
        logic [15:0] imm;
        int          kind;
        rs    = 5'(next_rand() % 8);         // Small set keeps operands dependent
        rt    = 5'(next_rand() % 8);
        rd    = 5'(next_rand() % 7 + 1);
        shamt = 5'(next_rand());
        imm   = 16'(next_rand());
        if (idx < 16) begin
            imm[15] = 1'b1;                  // Negative ADDI, high ORI bits
            return {(idx % 2 == 0) ? OP_ADDI : OP_ORI, rs, rd, imm};
        end
        kind = int'(next_rand() % 20);
        if (kind < 10) begin
            return {OP_RTYPE, rs, rt, rd, shamt, pick_funct()};
        end else if (kind < 13) begin
            return {OP_ADDI, rs, rd, imm};
        end else if (kind < 15) begin
            return {OP_ORI, rs, rd, imm};
        end else if (kind == 15) begin
            return {OP_RTYPE, rs, rt, 5'd0, shamt, pick_funct()}; // Targets r0
        end else if (kind == 16) begin
            return {OP_ADDI, rs, 5'd0, imm};
        end else if (kind == 17) begin
            opcode = 6'(next_rand());
            if (opcode == OP_RTYPE || opcode == OP_ADDI || opcode == OP_ORI) begin
                opcode = 6'd35;
            end
            return {opcode, rs, rd, imm};
        end else if (kind == 18) begin
            return {OP_RTYPE, rs, rt, rd, shamt, 6'(next_rand() % 32)}; // Unknown funct
        end
        rs = 5'(next_rand());
        rt = 5'(next_rand());
        rd = 5'(next_rand() % 31 + 1);       // Reach the upper registers
        return {OP_RTYPE, rs, rt, rd, shamt, pick_funct()};
    endfunction

    task automatic prepare_stimulus();
        for (int k = 0; k < N_INSTR; k++) begin
            instr_list[k] = make_instr(k);
            gap_list[k]   = (next_rand() % 10 < 7) ? 0 : int'(next_rand() % 3) + 1;
        end
        for (int k = 0; k < N_RAND_DBG; k++) begin
            dbg_gap[k] = int'(next_rand() % 21) + 10;
            dbg_adr[k] = 6'(next_rand() % 33);
        end
    endtask

    // Reference behavior of one accepted word
    task automatic apply_model(input logic [31:0] word);
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [15:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic        writes;
        opcode = word[31:26];
        rs     = word[25:21];
        rt     = word[20:16];
        imm    = word[15:0];
        dest   = word[15:11];
        a      = model_regs[rs];
        b      = model_regs[rt];
        result = 32'd0;
        writes = 1'b1;
        if (opcode == OP_RTYPE) begin
            case (word[5:0])
                FN_ADD:  result = a + b;
                FN_SUB:  result = a - b;
                FN_AND:  result = a & b;
                FN_OR:   result = a | b;
                FN_XOR:  result = a ^ b;
                FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: writes = 1'b0;
            endcase
        end else if (opcode == OP_ADDI) begin
            dest   = rt;
            result = a + {{16{imm[15]}}, imm};
        end else if (opcode == OP_ORI) begin
            dest   = rt;
            result = a | {16'd0, imm};
        end else begin
            writes = 1'b0;
        end
        if (writes && dest != 5'd0) begin
            model_regs[dest] = result;
        end
        model_count = model_count + 32'd1;   // No-ops retire too
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0d ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic wb_access(input logic we, input logic [5:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic ready_at_ack);
        @(posedge clock);
        wb_cyc    <= 1'b1;
        wb_stb    <= 1'b1;
        wb_we     <= we;
        wb_adr    <= adr;
        wb_dat_in <= wdata;
        @(posedge clock);
        while (!wb_ack) begin
            @(posedge clock);
        end
        rdata        = wb_dat_out;
        ready_at_ack = instr_ready;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic read_and_check(input logic [5:0] adr);
        logic [31:0] expected;
        logic [31:0] data;
        logic        ready_at_ack;
        wb_access(1'b0, adr, 32'd0, data, ready_at_ack);
        if (adr < 6'd32) begin
            expected = model_regs[adr[4:0]];
        end else if (adr == DBG_COUNT_ADDR) begin
            expected = model_count;
        end else begin
            expected = 32'd0;                // Unused debug word
        end
        check_value(data, expected, $sformatf("debug read of word %0d", adr));
        check_value(32'(ready_at_ack), 32'd0, "instruction ready while frozen");
    endtask

    task automatic write_and_check(input logic [5:0] adr, input logic [31:0] wdata);
        logic [31:0] data;
        logic        ready_at_ack;
        wb_access(1'b1, adr, wdata, data, ready_at_ack);
        check_value(32'(ready_at_ack), 32'd1, "instruction ready during debug write");
    endtask

    task automatic run_stream();
        int   next_idx;
        int   accepted;
        int   wait_cycles;
        logic presenting;
        next_idx    = 0;
        accepted    = 0;
        wait_cycles = 0;
        presenting  = 1'b0;
        while (accepted < N_INSTR) begin
            @(posedge clock);
            if (presenting && instr_ready) begin
                apply_model(instr_word);     // Accepted on this edge
                accepted++;
                presenting = 1'b0;
            end
            if (!presenting && next_idx < N_INSTR && wait_cycles >= gap_list[next_idx]) begin
                instr_valid <= 1'b1;
                instr_word  <= instr_list[next_idx];
                next_idx++;
                presenting  = 1'b1;
                wait_cycles = 0;
            end else if (!presenting) begin
                instr_valid <= 1'b0;
                wait_cycles++;
            end
        end
    endtask

    task automatic random_debug();
        for (int k = 0; k < N_RAND_DBG; k++) begin
            repeat (dbg_gap[k]) @(posedge clock);
            read_and_check(dbg_adr[k]);      // Stream keeps pushing meanwhile
        end
    endtask

    initial begin
        logic [31:0] wdata;
        clock       = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr_word  = 32'd0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 6'd0;
        wb_dat_in   = 32'd0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        rand_state  = 32'd97479;
        model_count = 32'd0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = 32'd0;
        end
        prepare_stimulus();
        wdata = {16'(next_rand()), 16'(next_rand())};
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        for (int adr = 0; adr <= 32; adr++) begin
            read_and_check(6'(adr));         // All clear after reset
        end
        fork
            run_stream();
            random_debug();
        join
        for (int adr = 0; adr <= 32; adr++) begin
            read_and_check(6'(adr));
        end
        write_and_check(6'd5, wdata);
        read_and_check(6'd5);                // Write must be ignored
        read_and_check(6'd33);
        read_and_check(6'd63);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/regbank_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module regbank_top #(
    parameter int NB_DATA    = regbank_pkg::NB_DATA,
    parameter int NB_ADDR    = regbank_pkg::NB_ADDR,
    parameter int BANK_DEPTH = regbank_pkg::BANK_DEPTH
) (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic               i_instr_valid,
    input  logic [31:0]        i_instr,
    output logic               o_instr_ready,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    input  logic               i_wb_we,
    input  logic [5:0]         i_wb_adr,
    input  logic [NB_DATA-1:0] i_wb_dat,
    output logic [NB_DATA-1:0] o_wb_dat,
    output logic               o_wb_ack
);

    logic               freeze;
    logic               busy;
    logic               retire;
    logic               dbg_enable;
    logic               dbg_read_enable;
    logic [NB_ADDR-1:0] dbg_read_address;

    bank_port_if #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) bank_port ();

    exec_pipeline #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) u_exec_pipeline (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_instr_ready (o_instr_ready),
        .i_freeze      (freeze),
        .o_busy        (busy),
        .o_retire      (retire),
        .bank_port     (bank_port.pipe)
    );

    registers_bank #(
        .NB_DATA    (NB_DATA),
        .NB_ADDR    (NB_ADDR),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_registers_bank (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .bank_port      (bank_port.bank),
        .i_enable       (dbg_enable),
        .i_read_enable  (dbg_read_enable),
        .i_read_address (dbg_read_address)
    );

    debug_unit #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) u_debug_unit (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_wb_cyc       (i_wb_cyc),
        .i_wb_stb       (i_wb_stb),
        .i_wb_we        (i_wb_we),
        .i_wb_adr       (i_wb_adr),
        .i_wb_dat       (i_wb_dat),
        .o_wb_dat       (o_wb_dat),
        .o_wb_ack       (o_wb_ack),
        .i_bank_data    (bank_port.data_a), // Debug word arrives on port A
        .i_busy         (busy),
        .i_retire       (retire),
        .o_freeze       (freeze),
        .o_bank_enable  (dbg_enable),
        .o_read_enable  (dbg_read_enable),
        .o_read_address (dbg_read_address)
    );

endmodule

`default_nettype wire

// ==== rtl/debug_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module debug_unit #(
    parameter int NB_DATA = regbank_pkg::NB_DATA,
    parameter int NB_ADDR = regbank_pkg::NB_ADDR
) (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    input  logic               i_wb_we,
    input  logic [5:0]         i_wb_adr,
    input  logic [NB_DATA-1:0] i_wb_dat,
    output logic [NB_DATA-1:0] o_wb_dat,
    output logic               o_wb_ack,
    input  logic [NB_DATA-1:0] i_bank_data,
    input  logic               i_busy,
    input  logic               i_retire,
    output logic               o_freeze,
    output logic               o_bank_enable,
    output logic               o_read_enable,
    output logic [NB_ADDR-1:0] o_read_address
);

    import regbank_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_DRAIN = 2'd1;
    localparam logic [1:0] ST_READ  = 2'd2;
    localparam logic [1:0] ST_ACK   = 2'd3;

    logic [1:0]         state;
    logic               wr_q;
    logic [5:0]         adr_q;
    logic [NB_DATA-1:0] cap_data;
    logic [NB_DATA-1:0] retire_count;
    logic               req;
    logic               adr_is_reg;

    assign req        = i_wb_cyc && i_wb_stb;
    assign adr_is_reg = adr_q < DBG_COUNT_ADDR;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= ST_IDLE;
            wr_q  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        wr_q  <= i_wb_we;
                        state <= i_wb_we ? ST_ACK : ST_DRAIN; // Writes skip the freeze
                    end
                end
                ST_DRAIN: if (!i_busy) state <= ST_READ;   // Wait for writebacks
                ST_READ:  state <= ST_ACK;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == ST_IDLE && req) begin
            adr_q    <= i_wb_adr;
            cap_data <= i_wb_dat;             // Echoed on a write ack
        end else if (state == ST_READ) begin
            cap_data <= (adr_q == DBG_COUNT_ADDR) ? retire_count : '0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            retire_count <= '0;
        end else if (i_retire) begin
            retire_count <= retire_count + 1'b1;
        end
    end

    assign o_freeze       = (state != ST_IDLE) && !wr_q;
    assign o_bank_enable  = !(o_freeze && state == ST_ACK); // Hold debug word
    assign o_read_enable  = (state == ST_READ);
    assign o_read_address = adr_q[NB_ADDR-1:0];
    assign o_wb_ack       = (state == ST_ACK);

    // Bank word is valid from the read edge on
    assign o_wb_dat = (!o_wb_ack)             ? '0 :
                      (!wr_q && adr_is_reg)   ? i_bank_data :
                                                cap_data;

endmodule

`default_nettype wire

// ==== rtl/exec_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_pipeline #(
    parameter int NB_DATA = regbank_pkg::NB_DATA,
    parameter int NB_ADDR = regbank_pkg::NB_ADDR
) (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_instr_valid,
    input  regbank_pkg::instr_t i_instr,
    output logic                o_instr_ready,
    input  logic                i_freeze,
    output logic                o_busy,
    output logic                o_retire,
    bank_port_if.pipe           bank_port
);

    import regbank_pkg::*;

    logic               accept;
    alu_op_t            dec_op;
    logic [NB_ADDR-1:0] dec_rd;
    logic [NB_DATA-1:0] dec_imm;
    logic               dec_use_imm;
    logic               dec_known;

    logic               ex_valid;
    logic               ex_we;
    logic               ex_use_imm;
    alu_op_t            ex_op;
    logic [NB_ADDR-1:0] ex_rd;
    logic [NB_ADDR-1:0] ex_rs;
    logic [NB_ADDR-1:0] ex_rt;
    logic [NB_DATA-1:0] ex_imm;
    logic [NB_DATA-1:0] op_a;
    logic [NB_DATA-1:0] op_b;
    logic [NB_DATA-1:0] alu_b;
    logic [NB_DATA-1:0] alu_result;

    logic               res_valid;
    logic               res_we;
    logic [NB_ADDR-1:0] res_rd;
    logic [NB_DATA-1:0] res_data;

    logic               wb_valid;
    logic [NB_ADDR-1:0] wb_rd;
    logic [NB_DATA-1:0] wb_data;

    assign o_instr_ready = !i_freeze;
    assign accept        = i_instr_valid && o_instr_ready;

    // Bank latches operands on the accept edge
    assign bank_port.read_reg_a = i_instr.r.rs;
    assign bank_port.read_reg_b = i_instr.r.rt;

    always_comb begin
        dec_op      = ALU_ADD;
        dec_rd      = i_instr.r.rd;
        dec_imm     = {{(NB_DATA-16){i_instr.i.imm[15]}}, i_instr.i.imm};
        dec_use_imm = 1'b0;
        dec_known   = 1'b1;
        case (i_instr.r.opcode)
            OP_RTYPE: begin
                case (i_instr.r.funct)
                    FN_ADD:  dec_op = ALU_ADD;
                    FN_SUB:  dec_op = ALU_SUB;
                    FN_AND:  dec_op = ALU_AND;
                    FN_OR:   dec_op = ALU_OR;
                    FN_XOR:  dec_op = ALU_XOR;
                    FN_SLT:  dec_op = ALU_SLT;
                    default: dec_known = 1'b0; // Retires as a no-op
                endcase
            end
            OP_ADDI: begin
                dec_rd      = i_instr.i.rt;
                dec_use_imm = 1'b1;
            end
            OP_ORI: begin
                dec_op      = ALU_OR;
                dec_rd      = i_instr.i.rt;
                dec_use_imm = 1'b1;
                dec_imm     = {{(NB_DATA-16){1'b0}}, i_instr.i.imm}; // Zero extended
            end
            default: dec_known = 1'b0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            ex_valid  <= 1'b0;
            ex_we     <= 1'b0;
            res_valid <= 1'b0;
            res_we    <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            ex_valid  <= accept;
            ex_we     <= accept && dec_known && (dec_rd != '0); // Never write r0
            res_valid <= ex_valid;
            res_we    <= ex_valid && ex_we;
            wb_valid  <= res_we;
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept) begin
            ex_op      <= dec_op;
            ex_rd      <= dec_rd;
            ex_rs      <= i_instr.r.rs;
            ex_rt      <= i_instr.r.rt;
            ex_imm     <= dec_imm;
            ex_use_imm <= dec_use_imm;
        end
        res_rd   <= ex_rd;
        res_data <= alu_result;
        wb_rd    <= res_rd;
        wb_data  <= res_data;
    end

    forward_unit #(
        .NB_DATA (NB_DATA),
        .NB_ADDR (NB_ADDR)
    ) u_forward_unit (
        .i_rs        (ex_rs),
        .i_rt        (ex_rt),
        .i_bank_a    (bank_port.data_a),
        .i_bank_b    (bank_port.data_b),
        .i_ex_valid  (res_we),
        .i_ex_rd     (res_rd),
        .i_ex_result (res_data),
        .i_wb_valid  (wb_valid),
        .i_wb_rd     (wb_rd),
        .i_wb_data   (wb_data),
        .o_op_a      (op_a),
        .o_op_b      (op_b)
    );

    assign alu_b = ex_use_imm ? ex_imm : op_b;

    alu #(
        .NB_DATA (NB_DATA)
    ) u_alu (
        .i_op     (ex_op),
        .i_a      (op_a),
        .i_b      (alu_b),
        .o_result (alu_result)
    );

    assign bank_port.write_reg  = res_rd;
    assign bank_port.write_data = res_data;
    assign bank_port.reg_write  = res_we;

    assign o_retire = res_valid;             // Cycle before the bank write
    assign o_busy   = ex_valid || res_valid;

endmodule

`default_nettype wire

// ==== rtl/forward_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module forward_unit #(
    parameter int NB_DATA = regbank_pkg::NB_DATA,
    parameter int NB_ADDR = regbank_pkg::NB_ADDR
) (
    input  logic [NB_ADDR-1:0] i_rs,
    input  logic [NB_ADDR-1:0] i_rt,
    input  logic [NB_DATA-1:0] i_bank_a,
    input  logic [NB_DATA-1:0] i_bank_b,
    input  logic               i_ex_valid,  // Result register holds a write
    input  logic [NB_ADDR-1:0] i_ex_rd,
    input  logic [NB_DATA-1:0] i_ex_result,
    input  logic               i_wb_valid,  // Write committed last edge
    input  logic [NB_ADDR-1:0] i_wb_rd,
    input  logic [NB_DATA-1:0] i_wb_data,
    output logic [NB_DATA-1:0] o_op_a,
    output logic [NB_DATA-1:0] o_op_b
);

    // Newest matching producer wins
    function automatic logic [NB_DATA-1:0] pick(
        input logic [NB_ADDR-1:0] reg_idx,
        input logic [NB_DATA-1:0] bank_val
    );
        if (i_ex_valid && (i_ex_rd == reg_idx)) begin
            return i_ex_result;
        end else if (i_wb_valid && (i_wb_rd == reg_idx)) begin
            return i_wb_data;
        end
        return bank_val;
    endfunction

    always_comb begin
        o_op_a = pick(i_rs, i_bank_a);
        o_op_b = pick(i_rt, i_bank_b);
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu #(
    parameter int NB_DATA = regbank_pkg::NB_DATA
) (
    input  regbank_pkg::alu_op_t i_op,
    input  logic [NB_DATA-1:0]   i_a,
    input  logic [NB_DATA-1:0]   i_b,
    output logic [NB_DATA-1:0]   o_result
);

    import regbank_pkg::*;

    logic less_than;

    assign less_than = $signed(i_a) < $signed(i_b); // Signed compare

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_SLT: o_result = {{(NB_DATA-1){1'b0}}, less_than};
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/registers_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module registers_bank #(
    parameter int NB_DATA    = regbank_pkg::NB_DATA,
    parameter int NB_ADDR    = regbank_pkg::NB_ADDR,
    parameter int BANK_DEPTH = regbank_pkg::BANK_DEPTH
) (
    input  logic               i_clock,
    input  logic               i_reset,
    bank_port_if.bank          bank_port,
    input  logic               i_enable,       // Low holds the outputs
    input  logic               i_read_enable,  // Debug read cycle
    input  logic [NB_ADDR-1:0] i_read_address
);

    logic [NB_DATA-1:0] registers [BANK_DEPTH];
    logic [NB_DATA-1:0] data_a_q;
    logic [NB_DATA-1:0] data_b_q;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int idx = 0; idx < BANK_DEPTH; idx++) begin
                registers[idx] <= '0;
            end
            data_a_q <= '0;
            data_b_q <= '0;
        end else if (i_enable) begin
            if (i_read_enable) begin
                data_a_q <= registers[i_read_address]; // Debug word on port A
            end else begin
                data_a_q <= registers[bank_port.read_reg_a];
                data_b_q <= registers[bank_port.read_reg_b];
                if (bank_port.reg_write) begin
                    registers[bank_port.write_reg] <= bank_port.write_data;
                end
            end
        end
    end

    // Read ports see the old value on a same-edge write
    assign bank_port.data_a = data_a_q;
    assign bank_port.data_b = data_b_q;

endmodule

`default_nettype wire

// ==== rtl/bank_port_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface bank_port_if #(
    parameter int NB_DATA = regbank_pkg::NB_DATA,
    parameter int NB_ADDR = regbank_pkg::NB_ADDR
);

    logic [NB_ADDR-1:0] read_reg_a;
    logic [NB_ADDR-1:0] read_reg_b;
    logic [NB_ADDR-1:0] write_reg;
    logic [NB_DATA-1:0] write_data;
    logic               reg_write;
    logic [NB_DATA-1:0] data_a;
    logic [NB_DATA-1:0] data_b;

    modport pipe (
        output read_reg_a, read_reg_b, write_reg, write_data, reg_write,
        input  data_a, data_b
    );

    modport bank (
        input  read_reg_a, read_reg_b, write_reg, write_data, reg_write,
        output data_a, data_b
    );

endinterface

`default_nettype wire

// ==== rtl/regbank_pkg.sv ====
`default_nettype none

package regbank_pkg;

    localparam int NB_DATA    = 32;
    localparam int NB_ADDR    = 5;
    localparam int BANK_DEPTH = 32;

    // One instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } instr_t;

    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_ADDI  = 6'd8;
    localparam logic [5:0] OP_ORI   = 6'd13;

    localparam logic [5:0] FN_ADD = 6'd32;
    localparam logic [5:0] FN_SUB = 6'd34;
    localparam logic [5:0] FN_AND = 6'd36;
    localparam logic [5:0] FN_OR  = 6'd37;
    localparam logic [5:0] FN_XOR = 6'd38;
    localparam logic [5:0] FN_SLT = 6'd42;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    localparam logic [5:0] DBG_COUNT_ADDR = 6'd32; // Retire counter word

endpackage

`default_nettype wire
